// ==== include/rv_defs.svh ====
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// datapath widths
//////////////////////////////////////////////////////////////////////

`define RV_XLEN            32   // data and pc width
`define RV_REG_ADDR_W      5    // register index
`define RV_INSTR_W         32

//////////////////////////////////////////////////////////////////////
// instruction fields
//////////////////////////////////////////////////////////////////////

`define RV_OPCODE_MSB      6    // low two bits are always 2'b11
`define RV_OPCODE_LSB      2
`define RV_RD_MSB          11
`define RV_RD_LSB          7
`define RV_RS1_MSB         19
`define RV_RS1_LSB         15
`define RV_RS2_MSB         24
`define RV_RS2_LSB         20
`define RV_FUNCT3_MSB      14
`define RV_FUNCT3_LSB      12
`define RV_FUNCT7_BIT30    30   // sub / arithmetic shift select

//////////////////////////////////////////////////////////////////////
// stream flow control
//////////////////////////////////////////////////////////////////////

`define RV_QUEUE_DEPTH     4    // also the source's initial credits
`define RV_RET_CREDITS     2    // retire credits held after reset
`define RV_CNT_W           3    // wide enough for both counts

`endif

// ==== src/rvPkg.sv ====
`include "rv_defs.svh"

package rvPkg;

  //////////////////////////////////////////////////////////////////////
  // major opcodes, instr[6:2]
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [`RV_OPCODE_MSB-`RV_OPCODE_LSB:0] {
    OpBranch = 5'b11_000,
    OpJal    = 5'b11_011,
    OpArithI = 5'b00_100,
    OpArithR = 5'b01_100,
    OpAuipc  = 5'b00_101,
    OpLui    = 5'b01_101
  } opcodeT;

  // alu operations, top two bits group the unit
  typedef enum logic [3:0] {
    AluAdd  = 4'b00_00,
    AluSub  = 4'b00_01,
    AluPass = 4'b00_11,  // forward operand b
    AluOr   = 4'b01_00,
    AluAnd  = 4'b01_01,
    AluXor  = 4'b01_11,
    AluSrl  = 4'b10_00,
    AluSra  = 4'b10_10,
    AluSll  = 4'b10_01,
    AluSlt  = 4'b11_01,
    AluSltu = 4'b11_11
  } aluOpT;

  // branch conditions, same as funct3
  typedef enum logic [`RV_FUNCT3_MSB-`RV_FUNCT3_LSB:0] {
    BrBeq  = 3'b000,
    BrBne  = 3'b001,
    BrBlt  = 3'b100,
    BrBge  = 3'b101,
    BrBltu = 3'b110,
    BrBgeu = 3'b111
  } brCondT;

  typedef enum logic [1:0] {
    WbAlu  = 2'd0,
    WbLink = 2'd1,  // pc+4
    WbNone = 2'd2
  } wbSelT;

endpackage

// ==== src/instrQueue.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module instrQueue (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   instrValid,
  input  logic [`RV_INSTR_W-1:0] instr,
  input  logic                   deq,
  output logic                   headValid,
  output logic [`RV_INSTR_W-1:0] headInstr,
  output logic                   instrCredit
);

  localparam int PtrW = $clog2(`RV_QUEUE_DEPTH);
  localparam logic [PtrW-1:0] LastIdx = PtrW'(`RV_QUEUE_DEPTH - 1);

  logic [`RV_INSTR_W-1:0] mem [`RV_QUEUE_DEPTH];
  logic [PtrW-1:0]        rdPtr;
  logic [PtrW-1:0]        wrPtr;
  logic [`RV_CNT_W-1:0]   count;
  logic                   full;
  logic                   push;
  logic                   pop;

  assign full      = (count == `RV_CNT_W'(`RV_QUEUE_DEPTH));
  assign push      = instrValid && !full;  // source holds credits, guard anyway
  assign pop       = deq && headValid;
  assign headValid = (count != '0);
  assign headInstr = mem[rdPtr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wrPtr] <= instr;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // pointers, fill count and credit return
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rdPtr       <= '0;
      wrPtr       <= '0;
      count       <= '0;
      instrCredit <= 1'b0;
    end else begin
      if (push) begin
        wrPtr <= (wrPtr == LastIdx) ? '0 : wrPtr + 1'b1;
      end
      if (pop) begin
        rdPtr <= (rdPtr == LastIdx) ? '0 : rdPtr + 1'b1;
      end
      count       <= count + `RV_CNT_W'(push) - `RV_CNT_W'(pop);
      instrCredit <= pop;  // one pulse per freed entry
    end
  end

endmodule

// ==== src/decodeUnit.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module decodeUnit (
  input  logic [`RV_INSTR_W-1:0]    instr,
  output rvPkg::aluOpT              aluOp,
  output logic                      useImm,
  output logic [`RV_XLEN-1:0]       imm,
  output rvPkg::wbSelT              wbSel,
  output logic                      isBranch,
  output logic                      isJal,
  output logic                      isAuipc,
  output rvPkg::brCondT             brCond,
  output logic [`RV_REG_ADDR_W-1:0] rs1,
  output logic [`RV_REG_ADDR_W-1:0] rs2,
  output logic [`RV_REG_ADDR_W-1:0] rd
);

  rvPkg::opcodeT                             opcode;
  logic [`RV_FUNCT3_MSB-`RV_FUNCT3_LSB:0]    funct3;
  logic                                      bit30;
  logic [`RV_XLEN-1:0]                       immI;
  logic [`RV_XLEN-1:0]                       immU;
  logic [`RV_XLEN-1:0]                       immJ;
  logic [`RV_XLEN-1:0]                       immB;
  rvPkg::aluOpT                              arithOp;

  assign opcode = rvPkg::opcodeT'(instr[`RV_OPCODE_MSB:`RV_OPCODE_LSB]);
  assign funct3 = instr[`RV_FUNCT3_MSB:`RV_FUNCT3_LSB];
  assign bit30  = instr[`RV_FUNCT7_BIT30];
  assign rs1    = instr[`RV_RS1_MSB:`RV_RS1_LSB];
  assign rs2    = instr[`RV_RS2_MSB:`RV_RS2_LSB];
  assign rd     = instr[`RV_RD_MSB:`RV_RD_LSB];

  //////////////////////////////////////////////////////////////////////
  // immediate formats
  //////////////////////////////////////////////////////////////////////

  assign immI = {{20{instr[31]}}, instr[31:20]};
  assign immU = {instr[31:12], 12'b0};
  assign immJ = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  assign immB = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

  // alu control from funct3 and bit 30
  always_comb begin
    case (funct3)
      3'b000: begin
        // bit 30 of an addi immediate must not select sub
        if (bit30 && (opcode == rvPkg::OpArithR)) begin
          arithOp = rvPkg::AluSub;
        end else begin
          arithOp = rvPkg::AluAdd;
        end
      end
      3'b001:  arithOp = rvPkg::AluSll;
      3'b010:  arithOp = rvPkg::AluSlt;
      3'b011:  arithOp = rvPkg::AluSltu;
      3'b100:  arithOp = rvPkg::AluXor;
      3'b101:  arithOp = bit30 ? rvPkg::AluSra : rvPkg::AluSrl;  // same split for srai
      3'b110:  arithOp = rvPkg::AluOr;
      default: arithOp = rvPkg::AluAnd;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // main control
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    aluOp    = rvPkg::AluAdd;
    useImm   = 1'b0;
    imm      = immI;
    wbSel    = rvPkg::WbNone;  // unknown opcode retires as a no-op
    isBranch = 1'b0;
    isJal    = 1'b0;
    isAuipc  = 1'b0;
    brCond   = rvPkg::brCondT'(funct3);
    case (opcode)
      rvPkg::OpArithR: begin
        aluOp = arithOp;
        wbSel = rvPkg::WbAlu;
      end
      rvPkg::OpArithI: begin
        aluOp  = arithOp;
        useImm = 1'b1;
        wbSel  = rvPkg::WbAlu;
      end
      rvPkg::OpLui: begin
        aluOp  = rvPkg::AluPass;
        useImm = 1'b1;
        imm    = immU;
        wbSel  = rvPkg::WbAlu;
      end
      rvPkg::OpAuipc: begin
        useImm  = 1'b1;
        imm     = immU;
        isAuipc = 1'b1;  // pc as operand a
        wbSel   = rvPkg::WbAlu;
      end
      rvPkg::OpJal: begin
        imm   = immJ;
        isJal = 1'b1;
        wbSel = rvPkg::WbLink;
      end
      rvPkg::OpBranch: begin
        aluOp    = rvPkg::AluSub;
        imm      = immB;
        isBranch = (funct3[2:1] != 2'b01);  // 010 and 011 are not branches
      end
      default: ;
    endcase
  end

endmodule

// ==== src/regFile.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module regFile (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [`RV_REG_ADDR_W-1:0] rs1,
  input  logic [`RV_REG_ADDR_W-1:0] rs2,
  output logic [`RV_XLEN-1:0]       rs1Data,
  output logic [`RV_XLEN-1:0]       rs2Data,
  input  logic                      wrEn,
  input  logic [`RV_REG_ADDR_W-1:0] wrAddr,
  input  logic [`RV_XLEN-1:0]       wrData
);

  logic [`RV_XLEN-1:0] regs [1:31];  // x0 has no storage
  logic                wrLive;

  assign wrLive = wrEn && (wrAddr != '0);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wrLive) begin
      regs[wrAddr] <= wrData;
    end
  end

  // write-through for the instruction issuing this cycle
  assign rs1Data = (rs1 == '0) ? '0 : (wrLive && wrAddr == rs1) ? wrData : regs[rs1];
  assign rs2Data = (rs2 == '0) ? '0 : (wrLive && wrAddr == rs2) ? wrData : regs[rs2];

endmodule

// ==== src/execUnit.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module execUnit (
  input  logic [`RV_XLEN-1:0] pc,
  input  logic [`RV_XLEN-1:0] opA,
  input  logic [`RV_XLEN-1:0] opB,
  input  logic [`RV_XLEN-1:0] imm,
  input  logic                useImm,
  input  rvPkg::aluOpT        aluOp,
  input  logic                isBranch,
  input  logic                isJal,
  input  logic                isAuipc,
  input  rvPkg::brCondT       brCond,
  output logic [`RV_XLEN-1:0] result,
  output logic [`RV_XLEN-1:0] nextPc
);

  logic [`RV_XLEN-1:0] a;
  logic [`RV_XLEN-1:0] b;
  logic [`RV_XLEN-1:0] sum;
  logic [`RV_XLEN-1:0] diff;
  logic [4:0]          shamt;
  logic                carry;  // set when a >= b unsigned
  logic                zf;
  logic                sf;
  logic                vf;
  logic                taken;

  assign a     = isAuipc ? pc : opA;
  assign b     = useImm ? imm : opB;
  assign shamt = b[4:0];
  assign sum   = a + b;

  //////////////////////////////////////////////////////////////////////
  // subtractor and flags, shared by slt and branches
  //////////////////////////////////////////////////////////////////////

  assign {carry, diff} = {1'b0, a} + {1'b0, ~b} + 33'd1;
  assign zf = (diff == '0);
  assign sf = diff[`RV_XLEN-1];
  assign vf = (a[`RV_XLEN-1] ^ b[`RV_XLEN-1]) & (a[`RV_XLEN-1] ^ diff[`RV_XLEN-1]);

  always_comb begin
    case (aluOp)
      rvPkg::AluSub:  result = diff;
      rvPkg::AluPass: result = b;
      rvPkg::AluOr:   result = a | b;
      rvPkg::AluAnd:  result = a & b;
      rvPkg::AluXor:  result = a ^ b;
      rvPkg::AluSrl:  result = a >> shamt;
      rvPkg::AluSra:  result = $signed(a) >>> shamt;
      rvPkg::AluSll:  result = a << shamt;
      rvPkg::AluSlt:  result = {{(`RV_XLEN-1){1'b0}}, sf ^ vf};
      rvPkg::AluSltu: result = {{(`RV_XLEN-1){1'b0}}, ~carry};
      default:        result = sum;
    endcase
  end

  // branch condition
  always_comb begin
    case (brCond)
      rvPkg::BrBeq:  taken = zf;
      rvPkg::BrBne:  taken = ~zf;
      rvPkg::BrBlt:  taken = sf ^ vf;
      rvPkg::BrBge:  taken = ~(sf ^ vf);
      rvPkg::BrBltu: taken = ~carry;
      rvPkg::BrBgeu: taken = carry;
      default:       taken = 1'b0;
    endcase
  end

  assign nextPc = (isJal || (isBranch && taken)) ? pc + imm : pc + `RV_XLEN'd4;

endmodule

// ==== src/rvCore.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module rvCore (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      instrValid,
  input  logic [`RV_INSTR_W-1:0]    instr,
  output logic                      instrCredit,
  output logic                      retValid,
  output logic [`RV_XLEN-1:0]       retPc,
  output logic [`RV_REG_ADDR_W-1:0] retRd,
  output logic                      retWe,
  output logic [`RV_XLEN-1:0]       retData,
  output logic [`RV_XLEN-1:0]       retNextPc,
  input  logic                      retCredit
);

  logic                      headValid;
  logic [`RV_INSTR_W-1:0]    headInstr;
  logic                      deq;
  logic                      advance;
  logic                      step;  // execute moves to retire
  logic [`RV_XLEN-1:0]       pc;
  logic [`RV_XLEN-1:0]       issuePc;
  logic [`RV_CNT_W-1:0]      retCnt;
  rvPkg::aluOpT              dAluOp;
  logic                      dUseImm;
  logic [`RV_XLEN-1:0]       dImm;
  rvPkg::wbSelT              dWbSel;
  logic                      dIsBranch;
  logic                      dIsJal;
  logic                      dIsAuipc;
  rvPkg::brCondT             dBrCond;
  logic [`RV_REG_ADDR_W-1:0] dRs1;
  logic [`RV_REG_ADDR_W-1:0] dRs2;
  logic [`RV_REG_ADDR_W-1:0] dRd;
  logic [`RV_XLEN-1:0]       rs1Data;
  logic [`RV_XLEN-1:0]       rs2Data;
  logic                      exValid;
  logic [`RV_XLEN-1:0]       exPc;
  logic [`RV_XLEN-1:0]       exOpA;
  logic [`RV_XLEN-1:0]       exOpB;
  logic [`RV_XLEN-1:0]       exImm;
  logic                      exUseImm;
  rvPkg::aluOpT              exAluOp;
  logic                      exIsBranch;
  logic                      exIsJal;
  logic                      exIsAuipc;
  rvPkg::brCondT             exBrCond;
  rvPkg::wbSelT              exWbSel;
  logic [`RV_REG_ADDR_W-1:0] exRs1;
  logic [`RV_REG_ADDR_W-1:0] exRs2;
  logic [`RV_REG_ADDR_W-1:0] exRd;
  logic [`RV_XLEN-1:0]       fwdA;
  logic [`RV_XLEN-1:0]       fwdB;
  logic [`RV_XLEN-1:0]       exResult;
  logic [`RV_XLEN-1:0]       exNextPc;
  logic                      exWe;
  logic [`RV_XLEN-1:0]       exWbData;

  // the credit held by a retire in flight is already spent
  assign advance = (retCnt > `RV_CNT_W'(retValid));
  assign deq     = advance && headValid;
  assign step    = advance && exValid;
  assign issuePc = exValid ? exNextPc : pc;

  instrQueue uQueue (
    .clk(clk), .rst(rst), .instrValid(instrValid), .instr(instr), .deq(deq),
    .headValid(headValid), .headInstr(headInstr), .instrCredit(instrCredit)
  );

  decodeUnit uDecode (
    .instr(headInstr), .aluOp(dAluOp), .useImm(dUseImm), .imm(dImm), .wbSel(dWbSel),
    .isBranch(dIsBranch), .isJal(dIsJal), .isAuipc(dIsAuipc), .brCond(dBrCond),
    .rs1(dRs1), .rs2(dRs2), .rd(dRd)
  );

  regFile uRegs (
    .clk(clk), .rst(rst), .rs1(dRs1), .rs2(dRs2), .rs1Data(rs1Data), .rs2Data(rs2Data),
    .wrEn(retValid && retWe), .wrAddr(retRd), .wrData(retData)
  );

  //////////////////////////////////////////////////////////////////////
  // execute stage with forwarding from retire
  //////////////////////////////////////////////////////////////////////

  assign fwdA = (retWe && retRd == exRs1) ? retData : exOpA;
  assign fwdB = (retWe && retRd == exRs2) ? retData : exOpB;

  execUnit uExec (
    .pc(exPc), .opA(fwdA), .opB(fwdB), .imm(exImm), .useImm(exUseImm), .aluOp(exAluOp),
    .isBranch(exIsBranch), .isJal(exIsJal), .isAuipc(exIsAuipc), .brCond(exBrCond),
    .result(exResult), .nextPc(exNextPc)
  );

  assign exWe     = (exWbSel != rvPkg::WbNone) && (exRd != '0);
  assign exWbData = !exWe ? '0 :
                    (exWbSel == rvPkg::WbLink) ? exPc + `RV_XLEN'd4 : exResult;

  always_ff @(posedge clk) begin
    if (deq) begin
      exPc       <= issuePc;
      exOpA      <= rs1Data;
      exOpB      <= rs2Data;
      exImm      <= dImm;
      exUseImm   <= dUseImm;
      exAluOp    <= dAluOp;
      exIsBranch <= dIsBranch;
      exIsJal    <= dIsJal;
      exIsAuipc  <= dIsAuipc;
      exBrCond   <= dBrCond;
      exWbSel    <= dWbSel;
      exRs1      <= dRs1;
      exRs2      <= dRs2;
      exRd       <= dRd;
    end
    if (step) begin
      retPc     <= exPc;
      retRd     <= exRd;
      retData   <= exWbData;
      retNextPc <= exNextPc;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // control state: valids, pc and retire credits
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      exValid  <= 1'b0;
      retValid <= 1'b0;
      retWe    <= 1'b0;
      pc       <= '0;
      retCnt   <= `RV_CNT_W'(`RV_RET_CREDITS);
    end else begin
      if (advance) begin
        exValid <= headValid;
      end
      retValid <= step;  // one cycle per instruction
      if (step) begin
        retWe <= exWe;
        pc    <= exNextPc;
      end
      retCnt <= retCnt - `RV_CNT_W'(retValid) + `RV_CNT_W'(retCredit);
    end
  end

endmodule

// ==== verif/rvCore_props.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module rvCoreProps (
  input logic                      clk,
  input logic                      rst,
  input logic                      instrValid,
  input logic                      deq,
  input logic                      retValid,
  input logic                      retWe,
  input logic [`RV_REG_ADDR_W-1:0] retRd,
  input logic [`RV_CNT_W-1:0]      retCnt
);

  logic [`RV_CNT_W-1:0] fill;  // shadow of queue occupancy

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fill <= '0;
    end else begin
      fill <= fill + `RV_CNT_W'(instrValid) - `RV_CNT_W'(deq);
    end
  end

  pushNotFull: assert property (@(posedge clk) disable iff (rst)
    instrValid |-> fill < `RV_CNT_W'(`RV_QUEUE_DEPTH))
    else $error("instruction pushed into a full queue");

  creditBound: assert property (@(posedge clk) disable iff (rst)
    retCnt <= `RV_CNT_W'(`RV_RET_CREDITS))
    else $error("retire credit count above its reset value");

  weHasRd: assert property (@(posedge clk) disable iff (rst) retWe |-> retRd != '0)
    else $error("register write reported for x0");

  retireOnCredit: assert property (@(posedge clk) disable iff (rst) retValid |-> retCnt != '0)
    else $error("retire without a retire credit");

endmodule

bind rvCore rvCoreProps uProps (
  .clk(clk), .rst(rst), .instrValid(instrValid), .deq(deq), .retValid(retValid),
  .retWe(retWe), .retRd(retRd), .retCnt(retCnt)
);

// ==== verif/rvCore_tb.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module rvCore_tb;

  localparam int WaitLimit  = 200;  // cycles per wait
  localparam int SinkRandom = 0;
  localparam int SinkEager  = 1;    // credit back on every retire
  localparam int SinkHold   = 2;
  localparam int SinkOnce   = 3;    // one credit, then hold

  logic                      clk;
  logic                      rst;
  logic                      instrValid;
  logic [`RV_INSTR_W-1:0]    instr;
  logic                      instrCredit;
  logic                      retValid;
  logic [`RV_XLEN-1:0]       retPc;
  logic [`RV_REG_ADDR_W-1:0] retRd;
  logic                      retWe;
  logic [`RV_XLEN-1:0]       retData;
  logic [`RV_XLEN-1:0]       retNextPc;
  logic                      retCredit;

  logic [31:0]               lfsr;
  logic [`RV_XLEN-1:0]       mRegs [32];  // reference register file
  logic [`RV_XLEN-1:0]       mPc;
  logic [`RV_XLEN-1:0]       expPc [$];
  logic [`RV_REG_ADDR_W-1:0] expRd [$];
  logic                      expWe [$];
  logic [`RV_XLEN-1:0]       expData [$];
  logic [`RV_XLEN-1:0]       expNext [$];
  logic [`RV_XLEN-1:0]       lastRetPc;
  int                        srcCredits;
  int                        sinkOwed;
  int                        sinkMode;
  int                        granted;
  int                        retires;
  int                        cycleNo;
  int                        prevRetCycle;
  int                        stallGaps;
  int                        checks;
  int                        errors;
  int                        testChecks;
  int                        testErrors;
  int                        tests;
  bit                        hung;

  rvCore DUT (
    .clk(clk), .rst(rst), .instrValid(instrValid), .instr(instr),
    .instrCredit(instrCredit), .retValid(retValid), .retPc(retPc), .retRd(retRd),
    .retWe(retWe), .retData(retData), .retNextPc(retNextPc), .retCredit(retCredit)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // random source and reference model
  //////////////////////////////////////////////////////////////////////

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  return (a < b) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b101: begin
        if (alt) return $signed(a) >>> b[4:0];
        else return a >> b[4:0];
      end
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branchRef(input logic [2:0] f3, input logic [31:0] a,
                                     input logic [31:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // per-cycle monitor, sink and checks
  //////////////////////////////////////////////////////////////////////

  task automatic failNote(input string what);
    errors++;
    $display("%s", what);
  endtask

  task automatic checkField(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s expected 0x%08h got 0x%08h", name, exp, got);
    end
  endtask

  task automatic checkRetire();
    logic                      we;
    logic [`RV_REG_ADDR_W-1:0] rd;
    retires++;
    sinkOwed++;
    lastRetPc = retPc;
    if (prevRetCycle >= 0 && cycleNo != prevRetCycle + 1) stallGaps++;
    prevRetCycle = cycleNo;
    checks++;
    if (retires > granted) failNote("more instructions retired than retire credits granted");
    if (expPc.size() == 0) begin
      failNote("retire seen with no instruction outstanding");
    end else begin
      we = expWe.pop_front();
      rd = expRd.pop_front();
      checkField("retPc", retPc, expPc.pop_front());
      checkField("retWe", 32'(retWe), 32'(we));
      checkField("retData", retData, expData.pop_front());
      checkField("retNextPc", retNextPc, expNext.pop_front());
      if (we) checkField("retRd", 32'(retRd), 32'(rd));  // rd field is immediate on branches
    end
  endtask

  // sample at the falling edge, then drive the next inputs
  task automatic clockStep();
    logic credit;
    @(negedge clk);
    cycleNo++;
    if (instrCredit) begin
      srcCredits++;
      checks++;
      if (srcCredits > `RV_QUEUE_DEPTH) failNote("instruction credit returned beyond queue depth");
    end
    if (retValid) checkRetire();
    credit = 1'b0;
    if (sinkOwed > 0) begin
      case (sinkMode)
        SinkRandom: credit = (randBits(1) != 0);
        SinkEager:  credit = 1'b1;
        SinkOnce:   credit = 1'b1;
        default:    credit = 1'b0;
      endcase
    end
    if (credit) begin
      sinkOwed--;
      granted++;
      if (sinkMode == SinkOnce) sinkMode = SinkHold;
    end
    retCredit  = credit;
    instrValid = 1'b0;
  endtask

  task automatic waitRetires(input int target, output int cycles);
    cycles = 0;
    while (retires < target && !hung) begin
      if (cycles == WaitLimit) begin
        $display("timed out waiting for instruction %0d to retire", target);
        hung = 1'b1;
      end else begin
        clockStep();
        cycles++;
      end
    end
  endtask

  task automatic drainPipe();
    int cycles;
    waitRetires(retires + expPc.size(), cycles);
    // then let the sink hand back every credit it owes
    cycles = 0;
    while (sinkOwed > 0 && !hung) begin
      if (cycles == WaitLimit) begin
        $display("retire credits still owed after %0d cycles", WaitLimit);
        hung = 1'b1;
      end else begin
        clockStep();
        cycles++;
      end
    end
  endtask

  task automatic reportTest(input string name);
    tests++;
    $display("%s: %0d checks, %0d errors", name, checks - testChecks, errors - testErrors);
    testChecks = checks;
    testErrors = errors;
  endtask

  //////////////////////////////////////////////////////////////////////
  // instruction source
  //////////////////////////////////////////////////////////////////////

  // model the instruction at mPc, then push it once a credit is held
  task automatic sendInstr(input logic [31:0] word, input logic [4:0] rd, input logic writes,
                           input logic [31:0] value, input logic [31:0] target);
    logic we;
    int   n;
    we = writes && (rd != 5'd0);
    expPc.push_back(mPc);
    expRd.push_back(rd);
    expWe.push_back(we);
    expData.push_back(we ? value : 32'd0);
    expNext.push_back(target);
    if (we) mRegs[rd] = value;
    mPc = target;
    clockStep();
    n = 0;
    while (srcCredits == 0 && !hung) begin
      if (n == WaitLimit) begin
        $display("no instruction credit came back within %0d cycles", WaitLimit);
        hung = 1'b1;
      end else begin
        clockStep();
        n++;
      end
    end
    if (!hung) begin
      instrValid = 1'b1;
      instr      = word;
      srcCredits--;
    end
  endtask

  task automatic arithReg(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                          input logic [4:0] rs1, input logic [4:0] rs2);
    sendInstr({1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'h33}, rd, 1'b1,
              aluRef(f3, alt, mRegs[rs1], mRegs[rs2]), mPc + 32'd4);
  endtask

  task automatic arithImm(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [11:0] imm);
    logic alt;
    alt = (f3 == 3'b101) && imm[10];  // srai
    sendInstr({imm, rs1, f3, rd, 7'h13}, rd, 1'b1,
              aluRef(f3, alt, mRegs[rs1], {{20{imm[11]}}, imm}), mPc + 32'd4);
  endtask

  task automatic loadUpper(input logic [4:0] rd, input logic [19:0] imm);
    sendInstr({imm, rd, 7'h37}, rd, 1'b1, {imm, 12'b0}, mPc + 32'd4);
  endtask

  task automatic addUpperPc(input logic [4:0] rd, input logic [19:0] imm);
    sendInstr({imm, rd, 7'h17}, rd, 1'b1, mPc + {imm, 12'b0}, mPc + 32'd4);
  endtask

  task automatic jumpLink(input logic [4:0] rd, input logic [20:0] off);
    sendInstr({off[20], off[10:1], off[11], off[19:12], rd, 7'h6f}, rd, 1'b1,
              mPc + 32'd4, mPc + {{11{off[20]}}, off});
  endtask

  task automatic branchOn(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2,
                          input logic [12:0] off);
    logic [31:0] target;
    target = branchRef(f3, mRegs[rs1], mRegs[rs2]) ? mPc + {{19{off[12]}}, off} : mPc + 32'd4;
    sendInstr({off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63},
              {off[4:1], off[11]}, 1'b0, 32'd0, target);
  endtask

  task automatic randomAlu();
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic        alt;
    logic [11:0] imm;
    f3  = 3'(randBits(3));
    rd  = 5'(randBits(3));  // x0..x7 keeps hazards frequent
    rs1 = 5'(randBits(3));
    rs2 = 5'(randBits(3));
    alt = (randBits(1) != 0) && (f3 == 3'b000 || f3 == 3'b101);
    if (randBits(1) != 0) begin
      arithReg(f3, alt, rd, rs1, rs2);
    end else begin
      case (f3)
        3'b001:  imm = {7'b0, 5'(randBits(5))};
        3'b101:  imm = {1'b0, 1'(randBits(1)), 5'b0, 5'(randBits(5))};
        default: imm = 12'(randBits(12));
      endcase
      arithImm(f3, rd, rs1, imm);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  task automatic checkResetState();
    int lat;
    for (int i = 0; i < 5; i++) begin
      clockStep();
      checks++;
      if (retValid || instrCredit) failNote("retValid or instrCredit active before first push");
    end
    arithImm(3'b000, 5'd1, 5'd0, 12'h5a3);
    waitRetires(1, lat);
    checks++;
    if (!hung && lat != 3) failNote($sformatf("first retire took %0d cycles instead of 3", lat));
    checkField("retPc", lastRetPc, 32'h0);
    reportTest("reset");
  endtask

  task automatic aluMix();
    sinkMode = SinkRandom;
    for (int i = 1; i < 8; i++) begin
      loadUpper(5'(i), 20'(randBits(20)));
      arithImm(3'b000, 5'(i), 5'(i), 12'(randBits(12)));
    end
    for (int i = 0; i < 60; i++) begin
      randomAlu();
      if (randBits(2) == 0) clockStep();  // idle gap
    end
    drainPipe();
    reportTest("alu mix");
  endtask

  task automatic forwardChain();
    logic [4:0] prev;
    logic [4:0] prev2;
    logic [4:0] rd;
    logic [2:0] f3;
    sinkMode = SinkEager;
    drainPipe();
    prev         = 5'd1;
    prev2        = 5'd2;
    prevRetCycle = -1;
    stallGaps    = 0;
    for (int i = 0; i < 12; i++) begin
      rd = 5'(1 + (i % 7));
      f3 = 3'(randBits(3));
      arithReg(f3, (f3 == 3'b000 || f3 == 3'b101) && (randBits(1) != 0), rd, prev, prev2);
      prev2 = prev;
      prev  = rd;
    end
    drainPipe();
    checks++;
    if (stallGaps != 0) failNote($sformatf("dependent chain retired with %0d gaps", stallGaps));
    reportTest("forwarding");
  endtask

  task automatic controlFlow();
    logic [2:0] conds [6];
    logic [4:0] r;
    conds    = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    sinkMode = SinkRandom;
    for (int round = 0; round < 3; round++) begin
      loadUpper(5'(randBits(3)), 20'(randBits(20)));
      addUpperPc(5'(randBits(3)), 20'(randBits(20)));
      arithImm(3'b000, 5'(1 + randBits(2)), 5'(randBits(3)), 12'(randBits(12)));
      jumpLink(5'(randBits(3)), {20'(randBits(20)), 1'b0});
      for (int c = 0; c < 6; c++) begin
        r = 5'(randBits(3));
        branchOn(conds[c], 5'(randBits(3)), 5'(randBits(3)), {12'(randBits(12)), 1'b0});
        branchOn(conds[c], r, r, {12'(randBits(12)), 1'b0});  // equal operands
      end
    end
    drainPipe();
    reportTest("control flow");
  endtask

  task automatic creditStall();
    int base;
    sinkMode = SinkEager;
    drainPipe();
    sinkMode = SinkHold;
    base     = retires;
    // two retire, one holds in execute, four fill the queue
    for (int i = 0; i < 7; i++) randomAlu();
    for (int i = 0; i < 20; i++) clockStep();
    checks++;
    if (retires - base != `RV_RET_CREDITS) begin
      failNote($sformatf("%0d retires on %0d retire credits", retires - base, `RV_RET_CREDITS));
    end
    checks++;
    if (srcCredits != 0) failNote($sformatf("source holds %0d credits at full queue", srcCredits));
    for (int k = 1; k <= 5; k++) begin
      sinkMode = SinkOnce;
      for (int i = 0; i < 6; i++) clockStep();
      checks++;
      if (retires - base != `RV_RET_CREDITS + k) begin
        failNote($sformatf("%0d retires after releasing %0d credits", retires - base, k));
      end
    end
    sinkMode = SinkRandom;
    drainPipe();
    reportTest("credit stall");
  endtask

  initial begin
    rst          = 1'b1;
    instrValid   = 1'b0;
    instr        = '0;
    retCredit    = 1'b0;
    lfsr         = 32'h4c6ae13a;
    mPc          = '0;
    lastRetPc    = '0;
    srcCredits   = `RV_QUEUE_DEPTH;
    sinkOwed     = 0;
    sinkMode     = SinkRandom;
    granted      = `RV_RET_CREDITS;
    retires      = 0;
    cycleNo      = 0;
    prevRetCycle = -1;
    stallGaps    = 0;
    checks       = 0;
    errors       = 0;
    testChecks   = 0;
    testErrors   = 0;
    tests        = 0;
    hung         = 1'b0;
    for (int i = 0; i < 32; i++) mRegs[i] = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    checkResetState();
    if (!hung) aluMix();
    if (!hung) forwardChain();
    if (!hung) controlFlow();
    if (!hung) creditStall();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (hung || errors != 0) begin
      $display("Test failed");
    end else begin
      $display("Test passed");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+include
src/rvPkg.sv
src/instrQueue.sv
src/decodeUnit.sv
src/regFile.sv
src/execUnit.sv
src/rvCore.sv
verif/rvCore_props.sv
verif/rvCore_tb.sv

// ==== Bender.yml ====
package:
  name: rv_core

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/rvPkg.sv
      - src/instrQueue.sv
      - src/decodeUnit.sv
      - src/regFile.sv
      - src/execUnit.sv
      - src/rvCore.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/rvCore_props.sv
      - verif/rvCore_tb.sv
